// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_vdpu
FILELIST  = vdpu.f
BUILD_DIR = obj_dir
PASS_MSG  = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Output goes to the terminal, grep decides the exit status
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== alu/lane_alu.sv ====
module lane_alu (
   input  logic                 clk_i,
   input  logic                 rstn_i,
   input  logic                 vld_i,
   input  vdpu_pkg::alu_op_e    op_i,
   input  vdpu_pkg::sew_e       sew_i,
   input  vdpu_pkg::lane_word_t a_i,
   input  vdpu_pkg::lane_word_t b_i,
   output logic                 vld_o,
   output vdpu_pkg::sew_e       sew_o,
   output vdpu_pkg::lane_word_t res_o
);

   import vdpu_pkg::*;

   // Low result bits depend only on low operand bits
   function automatic lane_word_t alu_calc(input alu_op_e op, input lane_word_t a,
                                           input lane_word_t b);
      unique case (op)
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_AND:  return a & b;
         OP_OR:   return a | b;
         OP_XOR:  return a ^ b;
         OP_MUL:  return a * b;
         default: return '0;
      endcase
   endfunction

   ////////////////////////////////////////////////////
   // Stage 1: operand registers
   ////////////////////////////////////////////////////
   logic       vld_q1, vld_q2;
   alu_op_e    op_q1;
   sew_e       sew_q1, sew_q2;
   lane_word_t a_q1, b_q1, res_q2;
   lane_word_t full_res, res_d;
   lane_word_t byte_res [4];

   always_ff @(posedge clk_i)
   begin
      if (!rstn_i)
      begin
         vld_q1 <= 1'b0;
         vld_q2 <= 1'b0;
      end
      else
      begin
         vld_q1 <= vld_i;
         vld_q2 <= vld_q1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      op_q1  <= op_i;
      sew_q1 <= sew_i;
      a_q1   <= a_i;
      b_q1   <= b_i;
   end

   ////////////////////////////////////////////////////
   // Stage 2: compute and register the result
   ////////////////////////////////////////////////////
   always_comb
   begin
      full_res = alu_calc(op_q1, a_q1, b_q1);
      for (int i = 0; i < 4; i++)
      begin
         byte_res[i] = alu_calc(op_q1, {24'b0, a_q1[8*i +: 8]}, {24'b0, b_q1[8*i +: 8]});
      end

      unique case (sew_q1)
         SEW8:    res_d = {byte_res[3][7:0], byte_res[2][7:0],
                           byte_res[1][7:0], byte_res[0][7:0]};  // No carry between bytes
         SEW16:   res_d = {16'b0, full_res[15:0]};
         default: res_d = full_res;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      sew_q2 <= sew_q1;
      res_q2 <= res_d;
   end

   assign vld_o = vld_q2;
   assign sew_o = sew_q2;
   assign res_o = res_q2;

endmodule

// ==== common/vdpu_pkg.sv ====
`include "vdpu_settings.svh"

package vdpu_pkg;

   localparam int LANE_IDX_W = $clog2(`VDPU_LANES);

   typedef logic [`VDPU_DW-1:0] lane_word_t;
   typedef lane_word_t [`VDPU_LANES-1:0] lane_vec_t;

   typedef enum logic [1:0] {
      SEW8  = 2'd0,
      SEW16 = 2'd1,
      SEW32 = 2'd2
   } sew_e;

   typedef enum logic [`VDPU_OP_W-1:0] {
      OP_ADD,
      OP_SUB,
      OP_AND,
      OP_OR,
      OP_XOR,
      OP_MUL
   } alu_op_e;

   // Source of ALU operand B
   typedef enum logic [1:0] {
      OP2_VEC,
      OP2_SCALAR,
      OP2_IMM
   } op2_sel_e;

   typedef struct packed {
      alu_op_e    op;
      sew_e       sew;
      op2_sel_e   op2_sel;
      lane_word_t scalar;
      logic [4:0] imm;          // Signed, extended to SEW
   } alu_ctrl_t;

   typedef struct packed {
      logic                  up;        // 1 moves data to higher lanes
      logic [LANE_IDX_W-1:0] amount;
      logic [1:0]            byte_sel;
   } slide_ctrl_t;

endpackage

// ==== common/vdpu_settings.svh ====
`ifndef VDPU_SETTINGS_SVH
`define VDPU_SETTINGS_SVH

////////////////////////////////////////////////////
// Datapath geometry
////////////////////////////////////////////////////

// Number of vector lanes, a multiple of four
`define VDPU_LANES 8

`define VDPU_DW 32          // Lane word width

// Register file read latency, issue to operands
`define VDPU_VRF_DELAY 4

`define VDPU_OP_W 3         // ALU opcode width

`endif

// ==== hw/ctrl_delay_line.sv ====
module ctrl_delay_line #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 1
) (
   input  logic     clk_i,
   input  logic     rstn_i,
   input  logic     vld_i,
   input  payload_t data_i,
   output logic     vld_o,
   output payload_t data_o
);

   if (DEPTH == 0)
   begin : g_bypass
      assign vld_o  = vld_i;
      assign data_o = data_i;
   end
   else
   begin : g_shift
      logic [DEPTH-1:0] stage_vld;
      payload_t         stage_data [DEPTH];

      always_ff @(posedge clk_i)
      begin
         if (!rstn_i)
         begin
            stage_vld <= '0;
         end
         else
         begin
            stage_vld[0] <= vld_i;
            for (int i = 1; i < DEPTH; i++)
            begin
               stage_vld[i] <= stage_vld[i-1];
            end
         end
      end

      // Payload follows the valid bits without reset
      always_ff @(posedge clk_i)
      begin
         stage_data[0] <= data_i;
         for (int i = 1; i < DEPTH; i++)
         begin
            stage_data[i] <= stage_data[i-1];
         end
      end

      assign vld_o  = stage_vld[DEPTH-1];
      assign data_o = stage_data[DEPTH-1];
   end

endmodule

// ==== hw/slide_unit.sv ====
`include "vdpu_settings.svh"

module slide_unit (
   input  logic                  clk_i,
   input  logic                  rstn_i,
   input  logic                  vld_i,
   input  vdpu_pkg::slide_ctrl_t ctrl_i,
   input  vdpu_pkg::lane_vec_t   data_i,
   output logic                  vld_o,
   output vdpu_pkg::lane_vec_t   data_o
);

   import vdpu_pkg::*;

   logic [LANE_IDX_W-1:0] src_lane [`VDPU_LANES];
   lane_vec_t             data_q;
   logic                  vld_q;

   // Source lane wraps around the lane ring
   always_comb
   begin
      for (int k = 0; k < `VDPU_LANES; k++)
      begin
         if (ctrl_i.up)
            src_lane[k] = LANE_IDX_W'(k) - ctrl_i.amount;
         else
            src_lane[k] = LANE_IDX_W'(k) + ctrl_i.amount;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rstn_i)
         vld_q <= 1'b0;
      else
         vld_q <= vld_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (vld_i)
      begin
         for (int k = 0; k < `VDPU_LANES; k++)
         begin
            data_q[k] <= {4{data_i[src_lane[k]][8*ctrl_i.byte_sel +: 8]}};  // Byte in all slots
         end
      end
   end

   assign vld_o  = vld_q;
   assign data_o = data_q;

endmodule

// ==== hw/vdpu_top.sv ====
`include "vdpu_settings.svh"

module vdpu_top (
   input  logic                                clk_i,
   input  logic                                rstn_i,
   // ALU issue
   input  logic                                issue_i,
   input  vdpu_pkg::alu_op_e                   op_i,
   input  vdpu_pkg::sew_e                      sew_i,
   input  vdpu_pkg::op2_sel_e                  op2_sel_i,
   input  vdpu_pkg::lane_word_t                scalar_i,
   input  logic [4:0]                          imm_i,
   // Register file operands, VRF_DELAY after issue
   input  vdpu_pkg::lane_vec_t                 vs1_i,
   input  vdpu_pkg::lane_vec_t                 vs2_i,
   // Slide issue
   input  logic                                slide_issue_i,
   input  logic                                slide_up_i,
   input  logic [vdpu_pkg::LANE_IDX_W-1:0]     slide_amount_i,
   input  logic [1:0]                          slide_byte_sel_i,
   output vdpu_pkg::lane_vec_t                 res_o,
   output logic                                res_vld_o,
   output vdpu_pkg::lane_vec_t                 slide_o,
   output logic                                slide_vld_o
);

   import vdpu_pkg::*;

   alu_ctrl_t   issue_ctrl, alu_ctrl_d;
   slide_ctrl_t slide_issue_ctrl, slide_ctrl_d;
   logic        alu_vld_d, slide_vld_d;
   lane_vec_t   alu_a, alu_b, alu_res;
   logic [`VDPU_LANES-1:0] lane_vld;
   sew_e        lane_sew [`VDPU_LANES];

   assign issue_ctrl = '{op: op_i, sew: sew_i, op2_sel: op2_sel_i,
                         scalar: scalar_i, imm: imm_i};
   assign slide_issue_ctrl = '{up: slide_up_i, amount: slide_amount_i,
                               byte_sel: slide_byte_sel_i};

   ////////////////////////////////////////////////////
   // Controls wait for the register file read
   ////////////////////////////////////////////////////
   ctrl_delay_line #(.payload_t(alu_ctrl_t), .DEPTH(`VDPU_VRF_DELAY)) alu_dly_inst (
      .clk_i(clk_i), .rstn_i(rstn_i),
      .vld_i(issue_i), .data_i(issue_ctrl),
      .vld_o(alu_vld_d), .data_o(alu_ctrl_d)
   );

   ctrl_delay_line #(.payload_t(slide_ctrl_t), .DEPTH(`VDPU_VRF_DELAY)) slide_dly_inst (
      .clk_i(clk_i), .rstn_i(rstn_i),
      .vld_i(slide_issue_i), .data_i(slide_issue_ctrl),
      .vld_o(slide_vld_d), .data_o(slide_ctrl_d)
   );

   operand_gather gather_inst (
      .ctrl_i(alu_ctrl_d), .vs1_i(vs1_i), .vs2_i(vs2_i),
      .a_o(alu_a), .b_o(alu_b)
   );

   for (genvar i = 0; i < `VDPU_LANES; i++)
   begin : g_lane
      lane_alu alu_inst (
         .clk_i(clk_i), .rstn_i(rstn_i),
         .vld_i(alu_vld_d), .op_i(alu_ctrl_d.op), .sew_i(alu_ctrl_d.sew),
         .a_i(alu_a[i]), .b_i(alu_b[i]),
         .vld_o(lane_vld[i]), .sew_o(lane_sew[i]), .res_o(alu_res[i])
      );
   end

   // All lanes run in lockstep, lane 0 carries the SEW
   result_scatter scatter_inst (
      .sew_i(lane_sew[0]), .res_i(alu_res), .res_o(res_o)
   );

   assign res_vld_o = &lane_vld;

   slide_unit slide_inst (
      .clk_i(clk_i), .rstn_i(rstn_i),
      .vld_i(slide_vld_d), .ctrl_i(slide_ctrl_d), .data_i(vs2_i),
      .vld_o(slide_vld_o), .data_o(slide_o)
   );

endmodule

// ==== shuffle/operand_gather.sv ====
`include "vdpu_settings.svh"

module operand_gather (
   input  vdpu_pkg::alu_ctrl_t ctrl_i,
   input  vdpu_pkg::lane_vec_t vs1_i,
   input  vdpu_pkg::lane_vec_t vs2_i,
   output vdpu_pkg::lane_vec_t a_o,
   output vdpu_pkg::lane_vec_t b_o
);

   import vdpu_pkg::*;

   localparam int G32 = `VDPU_LANES / 4;   // Lane groups per 32-bit element
   localparam int G16 = `VDPU_LANES / 2;   // Lane pairs per 16-bit element

   lane_vec_t  a16, a32, b16, b32;
   lane_vec_t  b_vec;
   lane_word_t scalar_sew, imm_sew;

   ////////////////////////////////////////////////////
   // Byte regrouping across lanes
   ////////////////////////////////////////////////////
   always_comb
   begin
      a16 = '0;
      b16 = '0;
      for (int b = 0; b < 2; b++)
         for (int p = 0; p < G16; p++)
            for (int j = 0; j < 2; j++)
            begin
               a16[b*G16+p][8*j +: 8] = vs1_i[2*p+j][8*b +: 8];
               b16[b*G16+p][8*j +: 8] = vs2_i[2*p+j][8*b +: 8];
            end

      for (int b = 0; b < 4; b++)
         for (int g = 0; g < G32; g++)
            for (int j = 0; j < 4; j++)
            begin
               a32[b*G32+g][8*j +: 8] = vs1_i[4*g+j][8*b +: 8];
               b32[b*G32+g][8*j +: 8] = vs2_i[4*g+j][8*b +: 8];
            end
   end

   // Scalar and immediate narrowed or widened to SEW
   always_comb
   begin
      unique case (ctrl_i.sew)
         SEW8:
         begin
            a_o        = vs1_i;
            b_vec      = vs2_i;
            scalar_sew = {4{ctrl_i.scalar[7:0]}};
            imm_sew    = {4{{3{ctrl_i.imm[4]}}, ctrl_i.imm}};
         end
         SEW16:
         begin
            a_o        = a16;
            b_vec      = b16;
            scalar_sew = {16'b0, ctrl_i.scalar[15:0]};
            imm_sew    = {16'b0, {11{ctrl_i.imm[4]}}, ctrl_i.imm};
         end
         default:
         begin
            a_o        = a32;
            b_vec      = b32;
            scalar_sew = ctrl_i.scalar;
            imm_sew    = {{27{ctrl_i.imm[4]}}, ctrl_i.imm};
         end
      endcase

      unique case (ctrl_i.op2_sel)
         OP2_SCALAR: b_o = {`VDPU_LANES{scalar_sew}};
         OP2_IMM:    b_o = {`VDPU_LANES{imm_sew}};
         default:    b_o = b_vec;
      endcase
   end

endmodule

// ==== shuffle/result_scatter.sv ====
`include "vdpu_settings.svh"

module result_scatter (
   input  vdpu_pkg::sew_e      sew_i,
   input  vdpu_pkg::lane_vec_t res_i,
   output vdpu_pkg::lane_vec_t res_o
);

   import vdpu_pkg::*;

   localparam int G32 = `VDPU_LANES / 4;
   localparam int G16 = `VDPU_LANES / 2;

   lane_vec_t res16, res32;

   ////////////////////////////////////////////////////
   // Inverse of the operand gather
   ////////////////////////////////////////////////////
   always_comb
   begin
      // Upper half of each lane carries no element in SEW16
      res16 = '0;
      for (int b = 0; b < 2; b++)
         for (int p = 0; p < G16; p++)
            for (int j = 0; j < 2; j++)
            begin
               res16[2*p+j][8*b +: 8] = res_i[b*G16+p][8*j +: 8];
            end

      for (int b = 0; b < 4; b++)
         for (int g = 0; g < G32; g++)
            for (int j = 0; j < 4; j++)
            begin
               res32[4*g+j][8*b +: 8] = res_i[b*G32+g][8*j +: 8];
            end
   end

   always_comb
   begin
      unique case (sew_i)
         SEW8:    res_o = res_i;     // Bytes stay in place
         SEW16:   res_o = res16;
         default: res_o = res32;
      endcase
   end

endmodule

// ==== testbench/tb_vdpu.sv ====
`include "vdpu_settings.svh"

module tb_vdpu;

   timeunit 1ns;
   timeprecision 100ps;

   import vdpu_pkg::*;

   localparam int N_ALU_ISSUES   = 76;
   localparam int N_SLIDE_ISSUES = 80;
   localparam int WATCHDOG_NS    = (N_ALU_ISSUES + N_SLIDE_ISSUES + 20) * 10;

   typedef struct packed {
      int        cyc;       // Cycle in which the valid pulse is due
      lane_vec_t data;
   } expect_t;

   logic                  clk_i            = 1'b0;
   logic                  rstn_i           = 1'b0;
   logic                  issue_i          = 1'b0;
   alu_op_e               op_i             = OP_ADD;
   sew_e                  sew_i            = SEW8;
   op2_sel_e              op2_sel_i        = OP2_VEC;
   lane_word_t            scalar_i         = '0;
   logic [4:0]            imm_i            = '0;
   lane_vec_t             vs1_i            = '0;
   lane_vec_t             vs2_i            = '0;
   logic                  slide_issue_i    = 1'b0;
   logic                  slide_up_i       = 1'b0;
   logic [LANE_IDX_W-1:0] slide_amount_i   = '0;
   logic [1:0]            slide_byte_sel_i = '0;
   lane_vec_t             res_o;
   logic                  res_vld_o;
   lane_vec_t             slide_o;
   logic                  slide_vld_o;

   expect_t    alu_q [$];
   expect_t    slide_q [$];
   string      alu_name_q [$];
   string      slide_name_q [$];
   lane_vec_t  vs1_sched [int];       // Operands keyed by drive cycle
   lane_vec_t  vs2_sched [int];
   logic [31:0] lfsr_state = 32'h8e30;
   int         data_errors   = 0;
   int         timing_errors = 0;
   int         stray_errors  = 0;

   alu_op_e    wide_ops [3] = '{OP_ADD, OP_SUB, OP_MUL};
   alu_op_e    imm_ops  [4] = '{OP_ADD, OP_SUB, OP_XOR, OP_MUL};
   logic [4:0] imm_vals [4] = '{5'h1f, 5'h10, 5'h0f, 5'h15};  // -1, -16, 15, -11

   vdpu_top UUT (.*);

   initial
   begin
      forever #5 clk_i = ~clk_i;
   end

   //////////////////////////////////////////////////
   // Random source
   //////////////////////////////////////////////////
   function automatic logic rand_bit();
      logic b;
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b)
         lfsr_state = lfsr_state ^ 32'h80200003;  // x^32 + x^22 + x^2 + x + 1
      return b;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         v = {v[30:0], rand_bit()};
      return v;
   endfunction

   function automatic lane_vec_t rand_vec();
      lane_vec_t v;
      for (int l = 0; l < `VDPU_LANES; l++)
         v[l] = rand_bits(32);
      return v;
   endfunction

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////
   function automatic lane_word_t apply_op(input alu_op_e op, input lane_word_t a,
                                           input lane_word_t b, input int width);
      lane_word_t mask;
      lane_word_t r;
      mask = (width == 32) ? 32'hffff_ffff : (32'd1 << width) - 32'd1;
      case (op)
         OP_ADD:  r = (a & mask) + (b & mask);
         OP_SUB:  r = (a & mask) - (b & mask);
         OP_AND:  r = a & b;
         OP_OR:   r = a | b;
         OP_XOR:  r = a ^ b;
         OP_MUL:  r = (a & mask) * (b & mask);   // Low SEW bits kept
         default: r = '0;
      endcase
      return r & mask;
   endfunction

   function automatic lane_vec_t model_alu(input alu_op_e op, input sew_e sew,
                                           input op2_sel_e sel, input lane_word_t scalar,
                                           input logic [4:0] imm, input lane_vec_t vs1,
                                           input lane_vec_t vs2);
      lane_vec_t  res;
      lane_word_t a;
      lane_word_t b;
      lane_word_t r;
      lane_word_t bconst;
      int         nbytes;
      nbytes = (sew == SEW8) ? 1 : (sew == SEW16) ? 2 : 4;
      bconst = (sel == OP2_SCALAR) ? scalar : {{27{imm[4]}}, imm};
      res    = '0;
      if (nbytes == 1)
      begin
         for (int l = 0; l < `VDPU_LANES; l++)
            for (int j = 0; j < 4; j++)
            begin
               a = {24'b0, vs1[l][8*j +: 8]};
               b = (sel == OP2_VEC) ? {24'b0, vs2[l][8*j +: 8]} : bconst;
               r = apply_op(op, a, b, 8);
               res[l][8*j +: 8] = r[7:0];
            end
      end
      else
      begin
         // Element bp of group g spans byte bp of nbytes neighbouring lanes
         for (int g = 0; g < `VDPU_LANES / nbytes; g++)
            for (int bp = 0; bp < nbytes; bp++)
            begin
               a = '0;
               b = '0;
               for (int j = 0; j < nbytes; j++)
               begin
                  a[8*j +: 8] = vs1[nbytes*g + j][8*bp +: 8];
                  b[8*j +: 8] = vs2[nbytes*g + j][8*bp +: 8];
               end
               if (sel != OP2_VEC)
                  b = bconst;
               r = apply_op(op, a, b, 8 * nbytes);
               for (int j = 0; j < nbytes; j++)
                  res[nbytes*g + j][8*bp +: 8] = r[8*j +: 8];
            end
      end
      return res;
   endfunction

   function automatic lane_vec_t model_slide(input logic up, input int amount,
                                             input int byte_sel, input lane_vec_t vs2);
      lane_vec_t res;
      int        src;
      for (int k = 0; k < `VDPU_LANES; k++)
      begin
         if (up)
            src = (k - amount + `VDPU_LANES) % `VDPU_LANES;
         else
            src = (k + amount) % `VDPU_LANES;
         res[k] = {4{vs2[src][8*byte_sel +: 8]}};
      end
      return res;
   endfunction

   //////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////
   task automatic check_vec(input string name, input lane_vec_t exp, input lane_vec_t act);
      if (act !== exp)
      begin
         $display("error %s: expected %h, actual %h", name, exp, act);
         data_errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("error %s valid: expected %b, actual %b", name, exp, act);
         timing_errors++;
      end
   endtask

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////
   task automatic issue_cycle(input logic do_alu, input alu_op_e op, input sew_e sew,
                              input op2_sel_e sel, input lane_word_t scalar,
                              input logic [4:0] imm, input logic do_slide, input logic up,
                              input logic [LANE_IDX_W-1:0] amount,
                              input logic [1:0] byte_sel, input string name);
      int        n;
      lane_vec_t vs1;
      lane_vec_t vs2;
      expect_t   e;
      @(posedge clk_i);
      n   = int'(($time - 5) / 10);
      vs1 = rand_vec();
      vs2 = rand_vec();
      vs1_sched[n + `VDPU_VRF_DELAY] = vs1;
      vs2_sched[n + `VDPU_VRF_DELAY] = vs2;
      issue_i          <= do_alu;
      op_i             <= op;
      sew_i            <= sew;
      op2_sel_i        <= sel;
      scalar_i         <= scalar;
      imm_i            <= imm;
      slide_issue_i    <= do_slide;
      slide_up_i       <= up;
      slide_amount_i   <= amount;
      slide_byte_sel_i <= byte_sel;
      if (do_alu)
      begin
         e.cyc  = n + `VDPU_VRF_DELAY + 2;  // Two ALU stages
         e.data = model_alu(op, sew, sel, scalar, imm, vs1, vs2);
         alu_q.push_back(e);
         alu_name_q.push_back(name);
      end
      if (do_slide)
      begin
         e.cyc  = n + `VDPU_VRF_DELAY + 1;
         e.data = model_slide(up, int'(amount), int'(byte_sel), vs2);
         slide_q.push_back(e);
         slide_name_q.push_back(name);
      end
   endtask

   task automatic alu_issue(input alu_op_e op, input sew_e sew, input op2_sel_e sel,
                            input lane_word_t scalar, input logic [4:0] imm,
                            input string name);
      issue_cycle(1'b1, op, sew, sel, scalar, imm, 1'b0, 1'b0, '0, 2'd0, name);
   endtask

   task automatic slide_issue(input logic up, input logic [LANE_IDX_W-1:0] amount,
                              input logic [1:0] byte_sel, input string name);
      issue_cycle(1'b0, OP_ADD, SEW8, OP2_VEC, '0, 5'd0, 1'b1, up, amount, byte_sel, name);
   endtask

   task automatic drain_pipeline();
      @(posedge clk_i);
      issue_i       <= 1'b0;
      slide_issue_i <= 1'b0;
      while (alu_q.size() > 0 || slide_q.size() > 0)
         @(posedge clk_i);
      repeat (3) @(posedge clk_i);  // No stray pulses afterwards
   endtask

   // Register file model drives operands VRF_DELAY cycles after issue
   always @(posedge clk_i)
   begin : drive_operands
      int n;
      n = int'(($time - 5) / 10);
      if (vs1_sched.exists(n))
      begin
         vs1_i <= vs1_sched[n];
         vs2_i <= vs2_sched[n];
         vs1_sched.delete(n);
         vs2_sched.delete(n);
      end
      else
      begin
         vs1_i <= '0;
         vs2_i <= '0;
      end
   end

   //////////////////////////////////////////////////
   // Output compare at mid cycle
   //////////////////////////////////////////////////
   always @(negedge clk_i)
   begin : compare_outputs
      int    m;
      logic  exp_vld;
      string tname;
      m = int'(($time - 10) / 10);
      exp_vld = (alu_q.size() > 0) && (alu_q[0].cyc == m);
      if (alu_q.size() > 0)
         tname = alu_name_q[0];
      else
         tname = "idle";
      if (res_vld_o === 1'b1 && alu_q.size() == 0)
      begin
         $display("Result valid pulse in cycle %0d with no ALU operation in flight", m);
         stray_errors++;
      end
      else
         check_bit(tname, exp_vld, res_vld_o);
      if (exp_vld)
      begin
         if (res_vld_o === 1'b1)
            check_vec(alu_name_q[0], alu_q[0].data, res_o);
         void'(alu_q.pop_front());
         void'(alu_name_q.pop_front());
      end

      exp_vld = (slide_q.size() > 0) && (slide_q[0].cyc == m);
      if (slide_q.size() > 0)
         tname = slide_name_q[0];
      else
         tname = "idle";
      if (slide_vld_o === 1'b1 && slide_q.size() == 0)
      begin
         $display("Slide valid pulse in cycle %0d with no slide in flight", m);
         stray_errors++;
      end
      else
         check_bit(tname, exp_vld, slide_vld_o);
      if (exp_vld)
      begin
         if (slide_vld_o === 1'b1)
            check_vec(slide_name_q[0], slide_q[0].data, slide_o);
         void'(slide_q.pop_front());
         void'(slide_name_q.pop_front());
      end
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns with operations still pending", WATCHDOG_NS);
      $display("Done: errors found");
      $finish;
   end

   initial
   begin
      repeat (2) @(posedge clk_i);
      rstn_i <= 1'b1;

      for (int i = 0; i < 24; i++)
         alu_issue(alu_op_e'(i % 6), SEW8, OP2_VEC, '0, 5'd0, "sew8_vector");

      // Cross-lane layouts
      for (int rep = 0; rep < 3; rep++)
         for (int s = 1; s < 3; s++)
            for (int i = 0; i < 3; i++)
               alu_issue(wide_ops[i], sew_e'(s), OP2_VEC, '0, 5'd0, "wide_vector");

      for (int s = 0; s < 3; s++)
      begin
         alu_issue(OP_ADD, sew_e'(s), OP2_SCALAR, rand_bits(32), 5'd0, "scalar_operand");
         alu_issue(OP_MUL, sew_e'(s), OP2_SCALAR, rand_bits(32), 5'd0, "scalar_operand");
         for (int i = 0; i < 4; i++)
            alu_issue(imm_ops[i], sew_e'(s), OP2_IMM, '0, imm_vals[i], "imm_operand");
      end

      for (int u = 0; u < 2; u++)
         for (int a = 0; a < `VDPU_LANES; a++)
            for (int b = 0; b < 4; b++)
               slide_issue(u[0], LANE_IDX_W'(a), 2'(b), "slide");

      // ALU and slide issued together every cycle
      for (int i = 0; i < 16; i++)
         issue_cycle(1'b1, alu_op_e'(rand_bits(3) % 6), sew_e'(rand_bits(2) % 3),
                     op2_sel_e'(rand_bits(2) % 3), rand_bits(32), 5'(rand_bits(5)),
                     1'b1, rand_bit(), LANE_IDX_W'(rand_bits(LANE_IDX_W)),
                     2'(rand_bits(2)), "mixed");

      drain_pipeline();

      $display("Error counts: data %0d, valid timing %0d, unexpected pulses %0d",
               data_errors, timing_errors, stray_errors);
      if (data_errors + timing_errors + stray_errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

// ==== vdpu.f ====
+incdir+common
common/vdpu_pkg.sv
hw/ctrl_delay_line.sv
shuffle/operand_gather.sv
shuffle/result_scatter.sv
alu/lane_alu.sv
hw/slide_unit.sv
hw/vdpu_top.sv
testbench/tb_vdpu.sv
